//--- q88_alu.f
rtl/q88_alu_pkg.sv
rtl/axil_write_side.sv
rtl/q88_multiplier.sv
rtl/q88_exec.sv
rtl/axil_read_side.sv
rtl/q88_alu_top.sv
testbench/q88_alu_tb.sv

//--- rtl/axil_read_side.sv
`timescale 1ns/1ps

module axil_read_side (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [q88_alu_pkg::axil_addr_w-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [q88_alu_pkg::axil_data_w-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    input  q88_alu_pkg::alu_result_t            result,
    input  logic                                result_valid,
    input  logic                                clear_done
);

    localparam int gap_w = q88_alu_pkg::axil_data_w - q88_alu_pkg::data_w - 3;

    q88_alu_pkg::alu_result_t               result_q;
    logic                                   done;
    logic                                   accept;
    logic [q88_alu_pkg::axil_data_w-1:0]    status;

    always_ff @(posedge clk)
    begin
        if (result_valid)
            result_q <= result;
    end

    // a fresh command wins over a late result from an older one
    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else if (clear_done)
            done <= 1'b0;
        else if (result_valid)
            done <= 1'b1;
    end

    assign status = {done, {gap_w{1'b0}}, result_q.precision_lost, result_q.overflow,
                     result_q.value};

    assign arready = arvalid && !rvalid;
    assign accept  = arready;

    always_ff @(posedge clk)
    begin
        if (reset)
            rvalid <= 1'b0;
        else if (accept)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (araddr == q88_alu_pkg::addr_status)
            begin
                rdata <= status;
                rresp <= q88_alu_pkg::resp_okay;
            end
            else
            begin
                rdata <= '0;
                rresp <= q88_alu_pkg::resp_slverr; // unmapped
            end
        end
    end

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- rtl/axil_write_side.sv
`timescale 1ns/1ps

module axil_write_side (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [q88_alu_pkg::axil_addr_w-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [q88_alu_pkg::axil_data_w-1:0] wdata,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    output q88_alu_pkg::alu_cmd_t               cmd,
    output logic                                cmd_valid
);

    logic                           accept;
    logic                           addr_ok;
    logic [q88_alu_pkg::data_w-1:0] op_a;
    logic [q88_alu_pkg::data_w-1:0] op_b;

    // address and data are taken together, one write at a time
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign accept  = awready;

    assign addr_ok = (awaddr == q88_alu_pkg::addr_op_a) ||
                     (awaddr == q88_alu_pkg::addr_op_b) ||
                     (awaddr == q88_alu_pkg::addr_cmd);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            op_a <= '0;
            op_b <= '0;
        end
        else if (accept)
        begin
            if (awaddr == q88_alu_pkg::addr_op_a)
                op_a <= wdata[q88_alu_pkg::data_w-1:0];
            if (awaddr == q88_alu_pkg::addr_op_b)
                op_b <= wdata[q88_alu_pkg::data_w-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            bvalid <= 1'b0;
        else if (accept)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            bresp <= addr_ok ? q88_alu_pkg::resp_okay : q88_alu_pkg::resp_slverr;
    end

    // command goes out in the accept cycle with the operands held right now
    assign cmd_valid = accept && (awaddr == q88_alu_pkg::addr_cmd);
    assign cmd.op    = q88_alu_pkg::alu_op_t'(wdata[0]);
    assign cmd.a     = op_a;
    assign cmd.b     = op_b;

    // write response must hold, unchanged, until the master takes it
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

//--- rtl/q88_alu_pkg.sv
package q88_alu_pkg;

    // datapath widths
    localparam int data_w     = 16;
    localparam int frac_w     = 8;   // Q8.8
    localparam int prod_w     = 32;
    localparam int mul_groups = 4;   // interleaved partial-product sums

    // AXI4-Lite bus widths
    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    // register map
    localparam logic [axil_addr_w-1:0] addr_op_a   = 8'h00;
    localparam logic [axil_addr_w-1:0] addr_op_b   = 8'h04;
    localparam logic [axil_addr_w-1:0] addr_cmd    = 8'h08;  // write launches an operation
    localparam logic [axil_addr_w-1:0] addr_status = 8'h10;  // read only

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic {
        op_add = 1'b0,
        op_mul = 1'b1
    } alu_op_t;

    typedef struct packed {
        alu_op_t           op;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
    } alu_cmd_t;

    typedef struct packed {
        logic [data_w-1:0] value;
        logic              overflow;
        logic              precision_lost;
    } alu_result_t;

endpackage

//--- rtl/q88_alu_top.sv
`timescale 1ns/1ps

module q88_alu_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [q88_alu_pkg::axil_addr_w-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [q88_alu_pkg::axil_data_w-1:0] wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [q88_alu_pkg::axil_addr_w-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [q88_alu_pkg::axil_data_w-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready
);

    q88_alu_pkg::alu_cmd_t    cmd;
    logic                     cmd_valid;
    q88_alu_pkg::alu_result_t result;
    logic                     result_valid;

    // wstrb has no effect, operand writes always take the low half
    axil_write_side u_write (
        .clk       (clk),
        .reset     (reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    q88_exec u_exec (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    axil_read_side u_read (
        .clk          (clk),
        .reset        (reset),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .result       (result),
        .result_valid (result_valid),
        .clear_done   (cmd_valid)  // launch clears done
    );

endmodule

//--- rtl/q88_exec.sv
`timescale 1ns/1ps

module q88_exec (
    input  logic                     clk,
    input  logic                     reset,
    input  q88_alu_pkg::alu_cmd_t    cmd,
    input  logic                     cmd_valid,
    output q88_alu_pkg::alu_result_t result,
    output logic                     result_valid
);

    localparam int hi_lsb = q88_alu_pkg::data_w + q88_alu_pkg::frac_w;

    logic [q88_alu_pkg::data_w:0]   sum;
    logic [q88_alu_pkg::data_w:0]   sum_q1;
    logic [q88_alu_pkg::data_w:0]   sum_q2;
    q88_alu_pkg::alu_op_t           op_q1;
    q88_alu_pkg::alu_op_t           op_q2;
    logic                           add_v1;
    logic                           add_v2;
    logic                           mul_start;
    logic [q88_alu_pkg::prod_w-1:0] product;
    logic                           mul_valid;

    assign sum       = {1'b0, cmd.a} + {1'b0, cmd.b}; // carry lands in the top bit
    assign mul_start = cmd_valid && (cmd.op == q88_alu_pkg::op_mul);

    q88_multiplier u_mul (
        .clk       (clk),
        .reset     (reset),
        .a_in      (cmd.a),
        .b_in      (cmd.b),
        .in_valid  (mul_start),
        .product   (product),
        .out_valid (mul_valid)
    );

    // add path delayed to line up with the multiplier
    always_ff @(posedge clk)
    begin
        sum_q1 <= sum;
        sum_q2 <= sum_q1;
        op_q1  <= cmd.op;
        op_q2  <= op_q1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            add_v1 <= 1'b0;
            add_v2 <= 1'b0;
        end
        else
        begin
            add_v1 <= cmd_valid && !mul_start;
            add_v2 <= add_v1;
        end
    end

    always_comb
    begin
        if (op_q2 == q88_alu_pkg::op_mul)
        begin
            result.value          = product[hi_lsb-1:q88_alu_pkg::frac_w];
            result.overflow       = |product[q88_alu_pkg::prod_w-1:hi_lsb];
            result.precision_lost = |product[q88_alu_pkg::frac_w-1:0];
        end
        else
        begin
            result.value          = sum_q2[q88_alu_pkg::data_w-1:0];
            result.overflow       = sum_q2[q88_alu_pkg::data_w];
            result.precision_lost = 1'b0;
        end
    end

    assign result_valid = add_v2 || mul_valid;

endmodule

//--- rtl/q88_multiplier.sv
`timescale 1ns/1ps

module q88_multiplier (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [q88_alu_pkg::data_w-1:0] a_in,
    input  logic [q88_alu_pkg::data_w-1:0] b_in,
    input  logic                           in_valid,
    output logic [q88_alu_pkg::prod_w-1:0] product,
    output logic                           out_valid
);

    logic [q88_alu_pkg::prod_w-1:0] a_ext;
    logic [q88_alu_pkg::prod_w-1:0] pp     [q88_alu_pkg::data_w];
    logic [q88_alu_pkg::prod_w-1:0] grp    [q88_alu_pkg::mul_groups];
    logic [q88_alu_pkg::prod_w-1:0] grp_q  [q88_alu_pkg::mul_groups];
    logic [q88_alu_pkg::prod_w-1:0] total;
    logic                           valid_q;

    // operand widened to the full product width
    assign a_ext = {{q88_alu_pkg::data_w{1'b0}}, a_in};

    always_comb
    begin
        for (int i = 0; i < q88_alu_pkg::data_w; i++)
            pp[i] = (a_ext << i) & {q88_alu_pkg::prod_w{b_in[i]}};
    end

    // top four rows fold back in reverse so every group gets four rows
    always_comb
    begin
        for (int g = 0; g < q88_alu_pkg::mul_groups; g++)
            grp[g] = '0;
        for (int i = 0; i < q88_alu_pkg::data_w; i++)
        begin
            if (i < q88_alu_pkg::data_w - q88_alu_pkg::mul_groups)
                grp[i % q88_alu_pkg::mul_groups] = grp[i % q88_alu_pkg::mul_groups] + pp[i];
            else
                grp[q88_alu_pkg::data_w - 1 - i] = grp[q88_alu_pkg::data_w - 1 - i] + pp[i];
        end
    end

    always_comb
    begin
        total = '0;
        for (int g = 0; g < q88_alu_pkg::mul_groups; g++)
            total = total + grp_q[g];
    end

    always_ff @(posedge clk)
    begin
        grp_q   <= grp;   // stage 1
        product <= total; // stage 2
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    // two cycles after a launch the grouped sums must give the plain product
    a_latency: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> ##2 (out_valid &&
                          product == {{q88_alu_pkg::data_w{1'b0}}, $past(a_in, 2)} *
                                     {{q88_alu_pkg::data_w{1'b0}}, $past(b_in, 2)})
    );

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module q88_alu_tb -f q88_alu.f -o q88_alu_sim &&
    ./obj_dir/q88_alu_sim | tee /dev/stderr | grep -qx "sim passed" ||
    exit 1

//--- testbench/q88_alu_tb.sv
`timescale 1ns/1ps

module q88_alu_tb;

    localparam int num_ops        = 230;
    localparam int timeout_cycles = num_ops * 40 + 500;

    logic        clk;
    logic        reset;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          errors;
    int          checks;
    logic        stim_done;
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];

    q88_alu_top dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // status word as the bus shows it once done is set
    function automatic logic [31:0] status_model(input logic op, input logic [15:0] a,
                                                 input logic [15:0] b);
        logic [31:0] prod;
        logic [16:0] sum;
        prod = {16'b0, a} * {16'b0, b};   // Q16.16
        sum  = {1'b0, a} + {1'b0, b};
        if (op)
            return {1'b1, 13'b0, |prod[7:0], |prod[31:24], prod[23:8]};
        else
            return {1'b1, 13'b0, 1'b0, sum[16], sum[15:0]};
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // called and left on a falling edge
    task automatic write_reg(input string name, input logic [7:0] addr, input logic [31:0] data,
                             input int hold, input logic [1:0] exp_resp);
        logic [1:0] resp;
        while (bvalid)
            @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        do
        begin
            @(posedge clk);
        end
        while (!(awready && wready));   // accepted on this rising edge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        assert (bvalid) else log_error({"no write response for ", name});
        for (int i = 0; i < hold; i++)
        begin
            @(negedge clk);
            assert (bvalid && bresp == resp)
                else log_error({"write response for ", name, " moved while bready was low"});
        end
        bready = 1'b1;
        expect_value({name, " bresp"}, {30'b0, exp_resp}, {30'b0, resp});
    endtask

    task automatic read_reg(input string name, input logic [7:0] addr, input int hold,
                            input logic [1:0] exp_resp, output logic [31:0] data);
        logic [1:0] resp;
        while (rvalid)
            @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        do
        begin
            @(posedge clk);
        end
        while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        assert (rvalid) else log_error({"no read response for ", name});
        for (int i = 0; i < hold; i++)
        begin
            @(negedge clk);
            assert (rvalid && rdata == data && rresp == resp)
                else log_error({"read response for ", name, " moved while rready was low"});
        end
        rready = 1'b1;
        expect_value({name, " rresp"}, {30'b0, exp_resp}, {30'b0, resp});
    endtask

    task automatic wait_done(input string name, input int hold, output logic [31:0] status);
        int tries;
        tries = 0;
        read_reg(name, q88_alu_pkg::addr_status, hold, q88_alu_pkg::resp_okay, status);
        while (!status[31] && tries < 20)
        begin
            tries++;
            read_reg(name, q88_alu_pkg::addr_status, hold, q88_alu_pkg::resp_okay, status);
        end
        assert (status[31]) else log_error({"done never came up for ", name});
    endtask

    task automatic run_op(input string name, input logic op, input logic [15:0] a,
                          input logic [15:0] b, input int hold);
        logic [31:0] status;
        write_reg(name, q88_alu_pkg::addr_op_a, {16'b0, a}, hold, q88_alu_pkg::resp_okay);
        write_reg(name, q88_alu_pkg::addr_op_b, {16'b0, b}, hold, q88_alu_pkg::resp_okay);
        write_reg(name, q88_alu_pkg::addr_cmd, {31'b0, op}, hold, q88_alu_pkg::resp_okay);
        wait_done(name, hold, status);
        expect_value(name, status_model(op, a, b), status);
    endtask

    initial
    begin
        logic [31:0] status;
        void'($urandom(28419));
        stim_done = 1'b0;
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hf;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        read_reg("reset status", q88_alu_pkg::addr_status, 0, q88_alu_pkg::resp_okay, status);
        expect_value("done after reset", 32'd0, {31'b0, status[31]});

        for (int i = 0; i < 100; i++)
            run_op("random add", 1'b0, 16'($urandom()), 16'($urandom()), 0);
        for (int i = 0; i < 100; i++)
            run_op("random mul", 1'b1, 16'($urandom()), 16'($urandom()), 0);

        run_op("1.0 x 1.0", 1'b1, 16'h0100, 16'h0100, 0);
        run_op("ffff + 1", 1'b0, 16'hffff, 16'h0001, 0);
        run_op("zero add", 1'b0, 16'h0000, 16'h0000, 0);
        run_op("zero mul", 1'b1, 16'h0000, 16'h1234, 0);
        run_op("ffff x ffff", 1'b1, 16'hffff, 16'hffff, 0);

        // multiply then add, the add result is the one that stays
        write_reg("b2b", q88_alu_pkg::addr_op_a, 32'h3a7f, 0, q88_alu_pkg::resp_okay);
        write_reg("b2b", q88_alu_pkg::addr_op_b, 32'h0291, 0, q88_alu_pkg::resp_okay);
        write_reg("b2b mul", q88_alu_pkg::addr_cmd, 32'd1, 0, q88_alu_pkg::resp_okay);
        write_reg("b2b add", q88_alu_pkg::addr_cmd, 32'd0, 0, q88_alu_pkg::resp_okay);
        read_reg("b2b", q88_alu_pkg::addr_status, 0, q88_alu_pkg::resp_okay, status);
        expect_value("b2b done in flight", 32'd0, {31'b0, status[31]});
        wait_done("b2b", 0, status);
        expect_value("b2b", status_model(1'b0, 16'h3a7f, 16'h0291), status);

        // status is read only and 0x0c is unmapped
        write_reg("bad write", q88_alu_pkg::addr_status, 32'h5555, 0, q88_alu_pkg::resp_slverr);
        read_reg("bad read", 8'h0c, 0, q88_alu_pkg::resp_slverr, status);
        expect_value("bad read data", 32'd0, status);
        write_reg("kept operands", q88_alu_pkg::addr_cmd, 32'd1, 0, q88_alu_pkg::resp_okay);
        wait_done("kept operands", 0, status);
        expect_value("kept operands", status_model(1'b1, 16'h3a7f, 16'h0291), status);

        for (int i = 0; i < 20; i++)
            run_op("back-pressure", 1'($urandom()), 16'($urandom()), 16'($urandom()),
                   $urandom_range(1, 6));

        stim_done = 1'b1;
    end

    initial
    begin
        string       name;
        logic [31:0] exp_v;
        logic [31:0] act_v;
        do
        begin
            @(negedge clk);
            while (act_q.size() > 0)
            begin
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                checks++;
                assert (exp_v == act_v)
                    else log_error($sformatf("FAILED %s expected %h actual %h", name, exp_v,
                                             act_v));
            end
        end
        while (!stim_done);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule
